// ==== hw/usb_phy_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// USB PHY pin types
// Transmit, receive and pull-up pin groups, line-state encoding and
// the width of the SE0 duration timer
//////////////////////////////////////////////////////////////////////

`default_nettype none

package usb_phy_pkg;

  // Transmit pin group, d at bit 0 up to oe at bit 4
  typedef struct packed {
    logic oe;
    logic dn;
    logic dp;
    logic se0;
    logic d;
  } usb_tx_t;

  // Receive pin group, d at bit 0
  typedef struct packed {
    logic dn;
    logic dp;
    logic d;
  } usb_rx_t;

  // Pull-up and receiver enables, dp_pullup_en at bit 0
  typedef struct packed {
    logic rx_enable;
    logic dn_pullup_en;
    logic dp_pullup_en;
  } usb_ctrl_t;

  // Attach and bus-reset tracking
  typedef enum logic [1:0] {
    LINE_DETACHED  = 2'd0,
    LINE_ATTACHED  = 2'd1,
    LINE_BUS_RESET = 2'd2
  } line_state_e;

  // SE0 cycle count and reset threshold share this width
  localparam int unsigned SE0_CNT_W = 16;
  typedef logic [SE0_CNT_W-1:0] se0_cnt_t;

endpackage

`default_nettype wire

// ==== hw/usb_phy_reg_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// USB PHY register map
// Word addresses, field positions and register layouts of the
// Wishbone register block
//////////////////////////////////////////////////////////////////////

`default_nettype none

package usb_phy_reg_pkg;

  // Word addresses
  typedef logic [1:0] reg_addr_t;
  typedef logic [31:0] reg_data_t;

  localparam reg_addr_t ADDR_DRIVE        = 2'd0;
  localparam reg_addr_t ADDR_SENSE        = 2'd1;
  localparam reg_addr_t ADDR_STATUS       = 2'd2;
  localparam reg_addr_t ADDR_RESET_CYCLES = 2'd3;

  // DRIVE: bit 0 en, bits 5:1 tx, bits 8:6 ctrl
  typedef struct packed {
    usb_phy_pkg::usb_ctrl_t ctrl;
    usb_phy_pkg::usb_tx_t   tx;
    logic                   en;
  } phy_drive_t;

  // SENSE: bits 2:0 synced rx, bit 3 VBUS, bits 8:4 engine tx
  typedef struct packed {
    usb_phy_pkg::usb_tx_t tx;
    logic                 pwr_sense;
    usb_phy_pkg::usb_rx_t rx;
  } phy_sense_t;

  localparam int unsigned DRIVE_W = $bits(phy_drive_t);
  localparam int unsigned SENSE_W = $bits(phy_sense_t);

  // STATUS: bits 1:0 line state, bit 2 sticky bus reset (W1C)
  localparam int unsigned STATUS_STATE_LSB     = 0;
  localparam int unsigned STATUS_BUS_RESET_BIT = 2;

  // SE0 cycles before a bus reset is flagged
  localparam usb_phy_pkg::se0_cnt_t RESET_CYCLES_DEFAULT = 16'd64;

endpackage

`default_nettype wire

// ==== hw/usb_phy_regs.sv ====
//////////////////////////////////////////////////////////////////////
// USB PHY register block
// Wishbone classic slave with pin override, pin sense, line status
// and bus-reset threshold registers
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module usb_phy_regs (
  input  wire                             clk_i,
  input  wire                             rst_n_i,

  // Wishbone classic slave
  input  wire                             wb_cyc_i,
  input  wire                             wb_stb_i,
  input  wire                             wb_we_i,
  input  usb_phy_reg_pkg::reg_addr_t      wb_adr_i,
  input  usb_phy_reg_pkg::reg_data_t      wb_dat_i,
  output usb_phy_reg_pkg::reg_data_t      wb_dat_o,
  output logic                            wb_ack_o,

  // Hardware side
  input  usb_phy_reg_pkg::phy_sense_t     sense_i,
  input  usb_phy_pkg::line_state_e        line_state_i,
  input  wire                             bus_reset_pulse_i,
  output usb_phy_reg_pkg::phy_drive_t     drive_o,
  output usb_phy_pkg::se0_cnt_t           reset_cycles_o,
  output logic                            bus_reset_irq_o
);

  logic                        req;
  logic                        wr_en;
  logic                        clr_bus_reset;
  logic                        ack_q;
  logic                        bus_reset_q;
  usb_phy_reg_pkg::phy_drive_t drive_q;
  usb_phy_pkg::se0_cnt_t       reset_cycles_q;
  usb_phy_reg_pkg::reg_data_t  rdata_d;
  usb_phy_reg_pkg::reg_data_t  rdata_q;

  //////////////////////////////////////////////////////////////////////
  // Bus handshake
  //////////////////////////////////////////////////////////////////////

  assign req = wb_cyc_i & wb_stb_i;

  // Write commits on the edge that ends the ack cycle, so the new
  // value shows up one cycle after ack
  assign wr_en = req & wb_we_i & ack_q;

  assign clr_bus_reset = wr_en && (wb_adr_i == usb_phy_reg_pkg::ADDR_STATUS) &&
                         wb_dat_i[usb_phy_reg_pkg::STATUS_BUS_RESET_BIT];

  // One-cycle ack; cleared while set so a held request is not acked twice
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req & ~ack_q;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      drive_q        <= '0;
      reset_cycles_q <= usb_phy_reg_pkg::RESET_CYCLES_DEFAULT;
    end else if (wr_en) begin
      // SENSE and STATUS have no writable storage here
      case (wb_adr_i)
        usb_phy_reg_pkg::ADDR_DRIVE:
          drive_q <= wb_dat_i[usb_phy_reg_pkg::DRIVE_W-1:0];
        usb_phy_reg_pkg::ADDR_RESET_CYCLES:
          reset_cycles_q <= wb_dat_i[usb_phy_pkg::SE0_CNT_W-1:0];
        default: ;
      endcase
    end
  end

  // Sticky bus reset, a new event beats a same-cycle clear
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bus_reset_q <= 1'b0;
    end else if (bus_reset_pulse_i) begin
      bus_reset_q <= 1'b1;
    end else if (clr_bus_reset) begin
      bus_reset_q <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read path
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rdata_d = '0;
    case (wb_adr_i)
      usb_phy_reg_pkg::ADDR_DRIVE:
        rdata_d[usb_phy_reg_pkg::DRIVE_W-1:0] = drive_q;
      usb_phy_reg_pkg::ADDR_SENSE:
        rdata_d[usb_phy_reg_pkg::SENSE_W-1:0] = sense_i;
      usb_phy_reg_pkg::ADDR_STATUS: begin
        rdata_d[usb_phy_reg_pkg::STATUS_STATE_LSB +: 2] = line_state_i;
        rdata_d[usb_phy_reg_pkg::STATUS_BUS_RESET_BIT]  = bus_reset_q;
      end
      default:
        rdata_d[usb_phy_pkg::SE0_CNT_W-1:0] = reset_cycles_q;
    endcase
  end

  // Read data captured with the request, valid alongside ack
  always_ff @(posedge clk_i) begin
    if (req & ~ack_q) begin
      rdata_q <= rdata_d;
    end
  end

  assign wb_dat_o        = rdata_q;
  assign wb_ack_o        = ack_q;
  assign drive_o         = drive_q;
  assign reset_cycles_o  = reset_cycles_q;
  assign bus_reset_irq_o = bus_reset_q;

  // Master may hold stb through ack; the slave must still not re-ack
  a_ack_single : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_o |=> !wb_ack_o
  );

endmodule

`default_nettype wire

// ==== hw/usb_iomux.sv ====
//////////////////////////////////////////////////////////////////////
// USB pin multiplexer
// Synchronizes receive and VBUS pads, selects engine or override
// values for the transmit and pull-up pads
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module usb_iomux (
  input  wire                          clk_i,
  input  wire                          rst_n_i,

  // Override from DRIVE register
  input  usb_phy_reg_pkg::phy_drive_t  drive_i,

  // Asynchronous pads
  input  usb_phy_pkg::usb_rx_t         usb_rx_i,
  input  wire                          usb_sense_i,

  // Engine controls
  input  usb_phy_pkg::usb_tx_t         eng_tx_i,
  input  usb_phy_pkg::usb_ctrl_t       eng_ctrl_i,

  // Pad drivers
  output usb_phy_pkg::usb_tx_t         usb_tx_o,
  output usb_phy_pkg::usb_ctrl_t       usb_ctrl_o,

  // Synchronized lines and sense snapshot
  output usb_phy_pkg::usb_rx_t         rx_o,
  output logic                         pwr_sense_o,
  output usb_phy_reg_pkg::phy_sense_t  sense_o
);

  // VBUS on top, receive pins below
  logic [$bits(usb_phy_pkg::usb_rx_t):0] sync_q1;
  logic [$bits(usb_phy_pkg::usb_rx_t):0] sync_q2;

  //////////////////////////////////////////////////////////////////////
  // Input synchronizers
  //////////////////////////////////////////////////////////////////////

  // Two flop stages, pad to output is two clocks
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= {usb_sense_i, usb_rx_i};
      sync_q2 <= sync_q1;
    end
  end

  assign rx_o        = sync_q2[$bits(usb_phy_pkg::usb_rx_t)-1:0];
  assign pwr_sense_o = sync_q2[$bits(usb_phy_pkg::usb_rx_t)];

  // Sense view: synced inputs plus what the engine is driving
  assign sense_o.rx        = rx_o;
  assign sense_o.pwr_sense = pwr_sense_o;
  assign sense_o.tx        = eng_tx_i;

  //////////////////////////////////////////////////////////////////////
  // Output pin mux
  //////////////////////////////////////////////////////////////////////

  // Plain mux for now. On silicon, dp/dn/d want glitch-free clock mux
  // cells here to keep rise and fall edges matched
  always_comb begin
    if (drive_i.en) begin
      usb_tx_o   = drive_i.tx;
      usb_ctrl_o = drive_i.ctrl;
    end else begin
      usb_tx_o   = eng_tx_i;
      usb_ctrl_o = eng_ctrl_i;
    end
  end

  // Engine owns the pads whenever the override is off
  a_engine_passthru : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !drive_i.en |-> (usb_tx_o == eng_tx_i) && (usb_ctrl_o == eng_ctrl_i)
  );

endmodule

`default_nettype wire

// ==== hw/usb_se0_timer.sv ====
//////////////////////////////////////////////////////////////////////
// SE0 duration timer
// Counts consecutive SE0 cycles and flags when the threshold is met
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module usb_se0_timer (
  input  wire                    clk_i,
  input  wire                    rst_n_i,
  input  usb_phy_pkg::usb_rx_t   rx_i,
  input  usb_phy_pkg::se0_cnt_t  reset_cycles_i,
  output logic                   se0_long_o
);

  logic                  se0;
  usb_phy_pkg::se0_cnt_t cnt_d;
  usb_phy_pkg::se0_cnt_t cnt_q;
  logic                  se0_long_q;

  // Both lines low on the synchronized pins
  assign se0 = ~rx_i.dp & ~rx_i.dn;

  // Clear outside SE0, saturate at full scale
  always_comb begin
    if (!se0) begin
      cnt_d = '0;
    end else if (cnt_q != '1) begin
      cnt_d = cnt_q + usb_phy_pkg::se0_cnt_t'(1);
    end else begin
      cnt_d = cnt_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q      <= '0;
      se0_long_q <= 1'b0;
    end else begin
      cnt_q      <= cnt_d;
      // Gated by se0 so a zero threshold cannot fire on an idle line
      se0_long_q <= se0 & (cnt_d >= reset_cycles_i);
    end
  end

  assign se0_long_o = se0_long_q;

  // Long SE0 must not look short again after count overflow
  a_no_wrap : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (se0 && cnt_q == '1) |=> (!se0 || cnt_q == '1)
  );

endmodule

`default_nettype wire

// ==== hw/usb_line_fsm.sv ====
//////////////////////////////////////////////////////////////////////
// USB line-state FSM
// Tracks attach from VBUS sense and host bus reset from long SE0
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module usb_line_fsm (
  input  wire                       clk_i,
  input  wire                       rst_n_i,
  input  wire                       pwr_sense_i,
  input  wire                       se0_long_i,
  output usb_phy_pkg::line_state_e  line_state_o,
  output logic                      bus_reset_pulse_o
);

  usb_phy_pkg::line_state_e state_d;
  usb_phy_pkg::line_state_e state_q;
  logic                     pulse_q;

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    if (!pwr_sense_i) begin
      // Loss of VBUS wins from any state
      state_d = usb_phy_pkg::LINE_DETACHED;
    end else begin
      case (state_q)
        usb_phy_pkg::LINE_DETACHED:
          state_d = usb_phy_pkg::LINE_ATTACHED;
        usb_phy_pkg::LINE_ATTACHED:
          if (se0_long_i) begin
            state_d = usb_phy_pkg::LINE_BUS_RESET;
          end
        usb_phy_pkg::LINE_BUS_RESET:
          // Host released SE0
          if (!se0_long_i) begin
            state_d = usb_phy_pkg::LINE_ATTACHED;
          end
        default:
          state_d = usb_phy_pkg::LINE_DETACHED;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // State and entry pulse
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= usb_phy_pkg::LINE_DETACHED;
      pulse_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // High in the first cycle of LINE_BUS_RESET only
      pulse_q <= (state_d == usb_phy_pkg::LINE_BUS_RESET) &&
                 (state_q != usb_phy_pkg::LINE_BUS_RESET);
    end
  end

  assign line_state_o      = state_q;
  assign bus_reset_pulse_o = pulse_q;

  // Register block counts one event per pulse
  a_pulse_single : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    bus_reset_pulse_o |=> !bus_reset_pulse_o
  );

endmodule

`default_nettype wire

// ==== hw/usb_phy_top.sv ====
//////////////////////////////////////////////////////////////////////
// USB PHY front end
// Register block, pin mux, SE0 timer and line-state FSM
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module usb_phy_top (
  input  wire                         clk_i,
  input  wire                         rst_n_i,

  // Wishbone classic slave
  input  wire                         wb_cyc_i,
  input  wire                         wb_stb_i,
  input  wire                         wb_we_i,
  input  usb_phy_reg_pkg::reg_addr_t  wb_adr_i,
  input  usb_phy_reg_pkg::reg_data_t  wb_dat_i,
  output usb_phy_reg_pkg::reg_data_t  wb_dat_o,
  output logic                        wb_ack_o,

  // Pads
  input  usb_phy_pkg::usb_rx_t        usb_rx_i,
  input  wire                         usb_sense_i,
  output usb_phy_pkg::usb_tx_t        usb_tx_o,
  output usb_phy_pkg::usb_ctrl_t      usb_ctrl_o,

  // Serial engine side
  input  usb_phy_pkg::usb_tx_t        eng_tx_i,
  input  usb_phy_pkg::usb_ctrl_t      eng_ctrl_i,
  output usb_phy_pkg::usb_rx_t        eng_rx_o,
  output logic                        eng_pwr_sense_o,
  output usb_phy_pkg::line_state_e    eng_line_state_o,

  output logic                        bus_reset_irq_o
);

  usb_phy_reg_pkg::phy_drive_t drive;
  usb_phy_reg_pkg::phy_sense_t sense;
  usb_phy_pkg::se0_cnt_t       reset_cycles;
  logic                        se0_long;
  logic                        bus_reset_pulse;

  usb_phy_regs u_regs (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .wb_cyc_i          (wb_cyc_i),
    .wb_stb_i          (wb_stb_i),
    .wb_we_i           (wb_we_i),
    .wb_adr_i          (wb_adr_i),
    .wb_dat_i          (wb_dat_i),
    .wb_dat_o          (wb_dat_o),
    .wb_ack_o          (wb_ack_o),
    .sense_i           (sense),
    .line_state_i      (eng_line_state_o),
    .bus_reset_pulse_i (bus_reset_pulse),
    .drive_o           (drive),
    .reset_cycles_o    (reset_cycles),
    .bus_reset_irq_o   (bus_reset_irq_o)
  );

  // Synced lines feed the engine, the timer and the FSM
  usb_iomux u_iomux (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .drive_i     (drive),
    .usb_rx_i    (usb_rx_i),
    .usb_sense_i (usb_sense_i),
    .eng_tx_i    (eng_tx_i),
    .eng_ctrl_i  (eng_ctrl_i),
    .usb_tx_o    (usb_tx_o),
    .usb_ctrl_o  (usb_ctrl_o),
    .rx_o        (eng_rx_o),
    .pwr_sense_o (eng_pwr_sense_o),
    .sense_o     (sense)
  );

  usb_se0_timer u_se0_timer (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .rx_i           (eng_rx_o),
    .reset_cycles_i (reset_cycles),
    .se0_long_o     (se0_long)
  );

  usb_line_fsm u_line_fsm (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .pwr_sense_i       (eng_pwr_sense_o),
    .se0_long_i        (se0_long),
    .line_state_o      (eng_line_state_o),
    .bus_reset_pulse_o (bus_reset_pulse)
  );

endmodule

`default_nettype wire

// ==== tb/usb_phy_tb.sv ====
//////////////////////////////////////////////////////////////////////
// USB PHY front end testbench
// Wishbone register access, pin mux, synchronizers, attach and
// host bus reset detection
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module usb_phy_tb;

  // Six short tests, the longest about 150 cycles, plus SE0 margin
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int ACK_LIMIT      = 16;

  // Pad patterns as {dn, dp, d}
  localparam logic [2:0] RX_IDLE = 3'b011;
  localparam logic [2:0] RX_SE0  = 3'b000;

  logic                       clk_i;
  logic                       rst_n_i;
  logic                       wb_cyc_i;
  logic                       wb_stb_i;
  logic                       wb_we_i;
  usb_phy_reg_pkg::reg_addr_t wb_adr_i;
  usb_phy_reg_pkg::reg_data_t wb_dat_i;
  usb_phy_reg_pkg::reg_data_t wb_dat_o;
  logic                       wb_ack_o;
  usb_phy_pkg::usb_rx_t       usb_rx_i;
  logic                       usb_sense_i;
  usb_phy_pkg::usb_tx_t       usb_tx_o;
  usb_phy_pkg::usb_ctrl_t     usb_ctrl_o;
  usb_phy_pkg::usb_tx_t       eng_tx_i;
  usb_phy_pkg::usb_ctrl_t     eng_ctrl_i;
  usb_phy_pkg::usb_rx_t       eng_rx_o;
  logic                       eng_pwr_sense_o;
  usb_phy_pkg::line_state_e   eng_line_state_o;
  logic                       bus_reset_irq_o;

  logic [31:0] rng_state;
  int          err_cnt;
  int          test_err_base;
  int          tests_run;
  int          tests_failed;
  int          cycle_cnt;

  usb_phy_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Run limit
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  // Ack is a single-cycle strobe
  a_ack_one_cycle : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_o |=> !wb_ack_o
  ) else begin
    $display("[FAIL] wb_ack_o: got 0x1, expected 0x0 in cycle after ack");
    err_cnt++;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Xorshift32
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond) else begin
      $display("ERROR: %s", what);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_cnt == test_err_base) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d check(s) failed", name, err_cnt - test_err_base);
    end
    test_err_base = err_cnt;
  endtask

  // Request held through the ack cycle, dropped on the next falling edge
  task automatic bus_cycle(input logic we, input usb_phy_reg_pkg::reg_addr_t adr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    int n;
    n = 0;
    @(negedge clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdata;
    while (!wb_ack_o && n < ACK_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    check_true(wb_ack_o, "no ack from the register block");
    rdata = wb_dat_o;
    @(negedge clk_i);
    check_val("wb_ack_o", 32'(wb_ack_o), 32'h0);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input usb_phy_reg_pkg::reg_addr_t adr, input logic [31:0] data);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input usb_phy_reg_pkg::reg_addr_t adr, output logic [31:0] data);
    bus_cycle(1'b0, adr, 32'h0, data);
  endtask

  // Returns on a falling edge, hit set if the state showed up in time
  task automatic wait_state(input usb_phy_pkg::line_state_e st, input int limit,
                            output bit hit);
    int n;
    n   = 0;
    hit = 1'b0;
    while (!hit && n < limit) begin
      @(negedge clk_i);
      n++;
      hit = (eng_line_state_o == st);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reg_access();
    logic [31:0] rd;
    // Detached encodes as 0, sticky bit clear
    wb_read(usb_phy_reg_pkg::ADDR_STATUS, rd);
    check_val("STATUS", rd & 32'h7, 32'h0);
    wb_write(usb_phy_reg_pkg::ADDR_DRIVE, 32'h0000_01a5);
    wb_read(usb_phy_reg_pkg::ADDR_DRIVE, rd);
    check_val("DRIVE", rd & 32'h1ff, 32'h1a5);
    wb_write(usb_phy_reg_pkg::ADDR_RESET_CYCLES, 32'h0000_c35a);
    wb_read(usb_phy_reg_pkg::ADDR_RESET_CYCLES, rd);
    check_val("RESET_CYCLES", rd & 32'hffff, 32'hc35a);
    wb_write(usb_phy_reg_pkg::ADDR_DRIVE, 32'h0);
    wb_write(usb_phy_reg_pkg::ADDR_RESET_CYCLES, 32'd64);
  endtask

  task automatic test_passthrough();
    logic [31:0] r;
    for (int i = 0; i < 50; i++) begin
      r = next_rand();
      @(negedge clk_i);
      eng_tx_i   = r[4:0];
      eng_ctrl_i = r[7:5];
      @(posedge clk_i);
      check_val("usb_tx_o", 32'(usb_tx_o), 32'(r[4:0]));
      check_val("usb_ctrl_o", 32'(usb_ctrl_o), 32'(r[7:5]));
    end
  endtask

  task automatic test_override();
    logic [31:0] r;
    logic [31:0] wdata;
    r     = next_rand();
    wdata = {23'd0, r[7:0], 1'b1};
    wb_write(usb_phy_reg_pkg::ADDR_DRIVE, wdata);
    // Engine keeps toggling, pads must hold the DRIVE fields
    for (int i = 0; i < 20; i++) begin
      r = next_rand();
      @(negedge clk_i);
      eng_tx_i   = r[4:0];
      eng_ctrl_i = r[7:5];
      @(posedge clk_i);
      check_val("usb_tx_o", 32'(usb_tx_o), 32'(wdata[5:1]));
      check_val("usb_ctrl_o", 32'(usb_ctrl_o), 32'(wdata[8:6]));
    end
    wb_write(usb_phy_reg_pkg::ADDR_DRIVE, 32'h0);
    @(posedge clk_i);
    check_val("usb_tx_o", 32'(usb_tx_o), 32'(r[4:0]));
  endtask

  task automatic test_sync_sense();
    logic [3:0]  prev1;
    logic [3:0]  prev2;
    logic [31:0] r;
    logic [31:0] rd;
    logic [31:0] exp;
    // Pads have been steady well over two cycles here
    prev1 = {usb_sense_i, usb_rx_i};
    prev2 = prev1;
    for (int i = 0; i < 40; i++) begin
      @(negedge clk_i);
      check_val("{eng_pwr_sense_o,eng_rx_o}", 32'({eng_pwr_sense_o, eng_rx_o}), 32'(prev2));
      r           = next_rand();
      usb_rx_i    = r[2:0];
      usb_sense_i = r[3];
      prev2       = prev1;
      prev1       = r[3:0];
    end
    r = next_rand();
    @(negedge clk_i);
    usb_rx_i    = r[2:0];
    usb_sense_i = r[3];
    eng_tx_i    = r[8:4];
    repeat (3) @(negedge clk_i);
    // SENSE layout: rx in 2:0, VBUS in 3, engine tx in 8:4
    exp      = 32'h0;
    exp[2:0] = {usb_rx_i.dn, usb_rx_i.dp, usb_rx_i.d};
    exp[3]   = usb_sense_i;
    exp[8:4] = {eng_tx_i.oe, eng_tx_i.dn, eng_tx_i.dp, eng_tx_i.se0, eng_tx_i.d};
    wb_read(usb_phy_reg_pkg::ADDR_SENSE, rd);
    check_val("SENSE", rd, exp);
    @(negedge clk_i);
    usb_rx_i    = RX_IDLE;
    usb_sense_i = 1'b0;
  endtask

  task automatic test_attach();
    bit hit;
    wait_state(usb_phy_pkg::LINE_DETACHED, 8, hit);
    check_true(hit, "line state did not settle to LINE_DETACHED");
    usb_sense_i = 1'b1;
    wait_state(usb_phy_pkg::LINE_ATTACHED, 4, hit);
    check_true(hit, "no LINE_ATTACHED within 4 cycles of VBUS rising");
    usb_sense_i = 1'b0;
    wait_state(usb_phy_pkg::LINE_DETACHED, 4, hit);
    check_true(hit, "no LINE_DETACHED within 4 cycles of VBUS falling");
  endtask

  task automatic test_bus_reset();
    bit          hit;
    bit          entered;
    logic [31:0] rd;
    usb_sense_i = 1'b1;
    wait_state(usb_phy_pkg::LINE_ATTACHED, 4, hit);
    check_true(hit, "no LINE_ATTACHED before bus reset test");
    wb_write(usb_phy_reg_pkg::ADDR_RESET_CYCLES, 32'd20);
    // Short SE0, well under threshold
    @(negedge clk_i);
    usb_rx_i = RX_SE0;
    repeat (10) @(negedge clk_i);
    usb_rx_i = RX_IDLE;
    repeat (30) begin
      @(negedge clk_i);
      check_val("bus_reset_irq_o", 32'(bus_reset_irq_o), 32'h0);
    end
    // Long SE0, state must hold in bus reset once it gets there
    usb_rx_i = RX_SE0;
    entered  = 1'b0;
    repeat (40) begin
      @(negedge clk_i);
      if (entered) begin
        check_val("eng_line_state_o", 32'(eng_line_state_o),
                  32'(usb_phy_pkg::LINE_BUS_RESET));
      end
      entered = entered || (eng_line_state_o == usb_phy_pkg::LINE_BUS_RESET);
    end
    check_true(entered, "line state never reached LINE_BUS_RESET during long SE0");
    check_val("bus_reset_irq_o", 32'(bus_reset_irq_o), 32'h1);
    usb_rx_i = RX_IDLE;
    wait_state(usb_phy_pkg::LINE_ATTACHED, 8, hit);
    check_true(hit, "no return to LINE_ATTACHED after SE0 ended");
    // Sticky bit 2 plus attached state
    wb_read(usb_phy_reg_pkg::ADDR_STATUS, rd);
    check_val("STATUS", rd & 32'h7, 32'h5);
    wb_write(usb_phy_reg_pkg::ADDR_STATUS, 32'h4);
    wb_read(usb_phy_reg_pkg::ADDR_STATUS, rd);
    check_val("STATUS", rd & 32'h7, 32'h1);
    check_val("bus_reset_irq_o", 32'(bus_reset_irq_o), 32'h0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rng_state     = 32'h3bf9;
    err_cnt       = 0;
    test_err_base = 0;
    tests_run     = 0;
    tests_failed  = 0;
    rst_n_i       = 1'b0;
    wb_cyc_i      = 1'b0;
    wb_stb_i      = 1'b0;
    wb_we_i       = 1'b0;
    wb_adr_i      = '0;
    wb_dat_i      = '0;
    usb_rx_i      = RX_IDLE;
    usb_sense_i   = 1'b0;
    eng_tx_i      = '0;
    eng_ctrl_i    = '0;
    repeat (8) @(negedge clk_i);
    rst_n_i = 1'b1;

    test_reg_access();
    end_test("register access");
    test_passthrough();
    end_test("pass-through");
    test_override();
    end_test("override");
    test_sync_sense();
    end_test("sync and sense");
    test_attach();
    end_test("attach");
    test_bus_reset();
    end_test("bus reset");

    $display("tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
hw/usb_phy_pkg.sv
hw/usb_phy_reg_pkg.sv
hw/usb_phy_regs.sv
hw/usb_iomux.sv
hw/usb_se0_timer.sv
hw/usb_line_fsm.sv
hw/usb_phy_top.sv
tb/usb_phy_tb.sv

// ==== Makefile ====
# Verilator flow for the USB PHY front end

TB_TOP := usb_phy_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TB_TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TB_TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TB_TOP)); echo "$$out"; echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf obj_dir
